/* bench/ext_fifo_properties.sv */
// ==================================================
// Concurrent assertions on the SRAM controller
// SRAM pin timing and full flag, bound to nobl_fifo
// ==================================================
`timescale 1ns/100ps

module ext_fifo_properties #(
   parameter int RAM_DEPTH = fifo_cfg_pkg::DEF_RAM_DEPTH
) (
   input logic                 ext_clk,
   input logic                 arst_n_i,
   input nobl_pkg::sram_bus_t  ram_i,
   input logic [RAM_DEPTH:0]   fill_cnt_i
);

   import nobl_pkg::*;

   localparam logic [RAM_DEPTH:0] FULL_CNT = (RAM_DEPTH+1)'(2 ** RAM_DEPTH);

   int unsigned fail_cnt = 0;   // Assertion failures so far

   // Write data exactly SRAM_LAT after its address, never otherwise
   a_wr_data: assert property (@(posedge ext_clk) disable iff (!arst_n_i)
      ram_i.d_oe == $past(!ram_i.we_n && !ram_i.ce1_n, SRAM_LAT))
      else begin
         fail_cnt++;
         $error("write data enable not SRAM_LAT cycles after a write address");
      end

   // Read data slot follows a read address
   a_rd_slot: assert property (@(posedge ext_clk) disable iff (!arst_n_i)
      !ram_i.oe_n == $past(ram_i.we_n && !ram_i.ce1_n, SRAM_LAT))
      else begin
         fail_cnt++;
         $error("output enable not SRAM_LAT cycles after a read address");
      end

   a_no_clash: assert property (@(posedge ext_clk) disable iff (!arst_n_i)
      !ram_i.oe_n |-> !ram_i.d_oe)   // No bus fight in a read slot
      else begin
         fail_cnt++;
         $error("write data driven during a read data slot");
      end

   // Full ring, so no write address on the pins in the next cycle
   a_full: assert property (@(posedge ext_clk) disable iff (!arst_n_i)
      (fill_cnt_i == FULL_CNT) |=> ram_i.we_n)
      else begin
         fail_cnt++;
         $error("write address issued with the SRAM ring full");
      end

endmodule

bind nobl_fifo ext_fifo_properties #(.RAM_DEPTH(RAM_DEPTH)) u_props (
   .ext_clk       (ext_clk),
   .arst_n_i      (arst_n_i),
   .ram_i         (ram_o),
   .fill_cnt_i    (fill_cnt)
);

/* bench/ext_fifo_tb.sv */
// ==================================================
// Testbench of the deep FIFO with an SRAM model
// Random traffic, reference queue, compare process
// ==================================================
`timescale 1ns/100ps

module ext_fifo_tb;

   import fifo_cfg_pkg::*;
   import nobl_pkg::*;

   localparam int RAM_DEPTH   = 6;                        // 64 halves
   localparam int RAM_WORDS   = (2 ** RAM_DEPTH) / 2;
   localparam int MAX_HELD    = RAM_WORDS + 2 * DEF_BUF_DEPTH;
   localparam int N_ORDER     = 200;
   localparam int N_BP        = 200;
   localparam int N_MIX       = 300;
   localparam int TOTAL_WORDS = N_ORDER + N_BP + MAX_HELD + N_MIX;
   localparam int WDOG_CYCLES = TOTAL_WORDS * 40 + 2000;

   logic       ext_clk = 1'b0;
   logic       arst_n_i;
   word_t      data_i;
   logic       src_rdy_i;
   logic       dst_rdy_o;
   word_t      data_o;
   logic       src_rdy_o;
   logic       dst_rdy_i;
   sram_bus_t  ram_o;
   half_t      ram_d_i;

   logic [31:0]  lcg_state = 32'h25b8_fefd;
   word_t        exp_q [$];                   // Words accepted, not yet out
   int           err_cnt = 0;
   int           in_cnt  = 0;
   int           out_cnt = 0;

   always #4 ext_clk = ~ext_clk;

   ext_fifo #(
      .RAM_DEPTH (RAM_DEPTH),
      .BUF_DEPTH (DEF_BUF_DEPTH)
   ) u_ext_fifo (
      .ext_clk   (ext_clk),
      .arst_n_i  (arst_n_i),
      .data_i    (data_i),
      .src_rdy_i (src_rdy_i),
      .dst_rdy_o (dst_rdy_o),
      .data_o    (data_o),
      .src_rdy_o (src_rdy_o),
      .dst_rdy_i (dst_rdy_i),
      .ram_o     (ram_o),
      .ram_d_i   (ram_d_i)
   );

   zbt_sram_model #(.ADDR_W(RAM_DEPTH)) u_sram (
      .ext_clk (ext_clk),
      .ram_i   (ram_o),
      .ram_d_o (ram_d_i)
   );

   function automatic logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic word_t random_word();
      logic [31:0] hi;
      logic [31:0] lo;
      hi = next_random();
      lo = next_random();
      return {hi[3:0], lo};
   endfunction

   // True pct times in a hundred, upper LCG bits only
   function automatic logic chance(input int pct);
      logic [31:0] r;
      r = next_random();
      return (int'(r[31:16]) % 100) < pct;
   endfunction

   // Expected stream, pushes accepted words and pops the head on delivery
   function automatic word_t ref_fifo(input logic push, input word_t w, input logic pop);
      word_t head;
      head = '0;
      if (pop) begin
         head = exp_q.pop_front();
      end
      if (push) begin
         exp_q.push_back(w);
      end
      return head;
   endfunction

   task automatic check_eq(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
      if (got !== exp) begin
         $display("ERROR %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
         err_cnt++;
      end
   endtask

   // Handshakes sampled at the rising edge, inputs stable since the falling one
   always @(posedge ext_clk) begin
      if (arst_n_i) begin
         if (src_rdy_o && dst_rdy_i) begin
            if (exp_q.size() == 0) begin
               $display("Word 0x%0h delivered with none expected at %0t", data_o, $time);
               err_cnt++;
            end else begin
               check_eq("data_o", data_o, ref_fifo(1'b0, '0, 1'b1));
            end
            out_cnt++;
         end
         if (src_rdy_i && dst_rdy_o) begin
            void'(ref_fifo(1'b1, data_i, 1'b0));
            in_cnt++;
         end
      end
   end

   // Offer n words with random gaps, then run until everything is out
   task automatic run_traffic(input int n_words, input int src_pct, input int dst_pct);
      int start_in;
      start_in = in_cnt;
      while ((in_cnt - start_in < n_words) || (out_cnt < in_cnt)) begin
         @(negedge ext_clk);
         data_i    = random_word();
         src_rdy_i = (in_cnt - start_in < n_words) && chance(src_pct);
         dst_rdy_i = chance(dst_pct);
      end
      @(negedge ext_clk);
      src_rdy_i = 1'b0;
      dst_rdy_i = 1'b0;
   endtask

   task automatic check_idle_pins();
      check_eq("dst_rdy_o", dst_rdy_o, 1'b1);
      check_eq("src_rdy_o", src_rdy_o, 1'b0);
      check_eq("ram_o.ce1_n", ram_o.ce1_n, 1'b1);
      check_eq("ram_o.we_n", ram_o.we_n, 1'b1);
      check_eq("ram_o.oe_n", ram_o.oe_n, 1'b1);
      check_eq("ram_o.d_oe", ram_o.d_oe, 1'b0);
   endtask

   task automatic end_test(input string name, input int err_start, input int words);
      $display("Test %-14s %4d words, %0d errors", name, words, err_cnt - err_start);
   endtask

   initial begin
      int t_err;
      int t_in;
      int low_run;
      int held;
      int total_err;
      arst_n_i  = 1'b0;
      data_i    = '0;
      src_rdy_i = 1'b0;
      dst_rdy_i = 1'b0;

      t_err = err_cnt;
      repeat (8) @(posedge ext_clk);
      @(negedge ext_clk);
      check_idle_pins();                      // Still in reset
      arst_n_i = 1'b1;
      repeat (4) @(negedge ext_clk);
      check_idle_pins();                      // Released, nothing offered
      end_test("reset", t_err, 0);

      t_err = err_cnt;
      run_traffic(N_ORDER, 100, 100);
      end_test("order", t_err, N_ORDER);

      t_err = err_cnt;
      run_traffic(N_BP, 100, 50);
      end_test("backpressure", t_err, N_BP);

      // Sink stopped, fill until the input stays blocked
      t_err   = err_cnt;
      t_in    = in_cnt;
      low_run = 0;
      while (low_run < 20) begin
         @(negedge ext_clk);
         low_run   = dst_rdy_o ? 0 : low_run + 1;
         data_i    = random_word();
         src_rdy_i = 1'b1;
         dst_rdy_i = 1'b0;
      end
      src_rdy_i = 1'b0;
      held = in_cnt - t_in;
      if (held < RAM_WORDS || held > MAX_HELD) begin
         $display("Full test accepted %0d words, outside %0d to %0d", held, RAM_WORDS,
                  MAX_HELD);
         err_cnt++;
      end
      run_traffic(0, 0, 100);                 // Drain only
      end_test("full", t_err, held);

      t_err = err_cnt;
      run_traffic(N_MIX, 60, 70);
      check_eq("ref queue size", exp_q.size(), 0);
      end_test("mixed", t_err, N_MIX);

      total_err = err_cnt + int'(u_ext_fifo.u_nobl_fifo.u_props.fail_cnt);
      $display("Done: %0d words in, %0d out, %0d check errors, %0d assertion failures",
               in_cnt, out_cnt, err_cnt, u_ext_fifo.u_nobl_fifo.u_props.fail_cnt);
      if (total_err == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

   // Bound on run length, generous per word
   initial begin
      repeat (WDOG_CYCLES) @(posedge ext_clk);
      $display("Timeout: tests still running after %0d clock cycles", WDOG_CYCLES);
      $display("RESULT: FAIL");
      $finish;
   end

endmodule

/* bench/zbt_sram_model.sv */
// ==================================================
// Pipelined NoBL / ZBT SRAM model, 18 bit data
// Address to data latency SRAM_LAT for both directions
// ==================================================
`timescale 1ns/100ps

module zbt_sram_model #(
   parameter int ADDR_W = fifo_cfg_pkg::DEF_RAM_DEPTH
) (
   input  logic                 ext_clk,
   input  nobl_pkg::sram_bus_t  ram_i,
   output fifo_cfg_pkg::half_t  ram_d_o
);

   import fifo_cfg_pkg::*;
   import nobl_pkg::*;

   half_t                mem [2**ADDR_W];
   logic [SRAM_LAT-1:0]  wr_vld;              // Top bit is in its data cycle
   logic [ADDR_W-1:0]    wr_adr [SRAM_LAT];
   logic                 rd_vld;              // Read captured on the last edge
   logic [ADDR_W-1:0]    rd_adr;
   half_t                dq_q;                // Output data register
   logic                 access;
   logic                 wr_now;

   assign access  = !ram_i.ce_n && !ram_i.ld_n && !ram_i.ce1_n;
   assign wr_now  = wr_vld[SRAM_LAT-1] && ram_i.d_oe;
   assign ram_d_o = ram_i.oe_n ? '0 : dq_q;   // Bus parked low when not driven

   always_ff @(posedge ext_clk) begin
      if (wr_now) begin
         mem[wr_adr[SRAM_LAT-1]] <= ram_i.d_out;
      end
      if (rd_vld) begin
         // Late write forwarding
         if (wr_now && (wr_adr[SRAM_LAT-1] == rd_adr)) begin
            dq_q <= ram_i.d_out;
         end else begin
            dq_q <= mem[rd_adr];
         end
      end
      wr_vld    <= SRAM_LAT'({wr_vld, access && !ram_i.we_n});
      wr_adr[0] <= ram_i.address[ADDR_W-1:0];
      for (int i = 1; i < SRAM_LAT; i++) begin
         wr_adr[i] <= wr_adr[i-1];
      end
      rd_vld <= access && ram_i.we_n;
      rd_adr <= ram_i.address[ADDR_W-1:0];
   end

endmodule

/* ext_fifo.f */
hdl/fifo_cfg_pkg.sv
hdl/nobl_pkg.sv
hdl/word_split.sv
hdl/nobl_fifo.sv
hdl/word_join.sv
hdl/ext_fifo.sv
bench/zbt_sram_model.sv
bench/ext_fifo_properties.sv
bench/ext_fifo_tb.sv

/* hdl/ext_fifo.sv */
// ==================================================
// Deep 36 bit FIFO over an external NoBL SRAM
// Input split stage, SRAM controller, join stage
// ==================================================
`timescale 1ns/100ps

module ext_fifo #(
   parameter int RAM_DEPTH = fifo_cfg_pkg::DEF_RAM_DEPTH,   // SRAM address bits
   parameter int BUF_DEPTH = fifo_cfg_pkg::DEF_BUF_DEPTH    // Words per stage buffer
) (
   input  logic                 ext_clk,
   input  logic                 arst_n_i,
   input  fifo_cfg_pkg::word_t  data_i,
   input  logic                 src_rdy_i,    // Write
   output logic                 dst_rdy_o,    // Not full
   output fifo_cfg_pkg::word_t  data_o,
   output logic                 src_rdy_o,    // Not empty
   input  logic                 dst_rdy_i,    // Read
   output nobl_pkg::sram_bus_t  ram_o,
   input  fifo_cfg_pkg::half_t  ram_d_i
);

   import fifo_cfg_pkg::*;

   half_t  write_data;
   logic   write_strobe;
   logic   space_avail;
   half_t  read_data;
   logic   data_avail;
   logic   read_strobe;

   word_split #(.BUF_DEPTH(BUF_DEPTH)) u_word_split (
      .ext_clk        (ext_clk),
      .arst_n_i       (arst_n_i),
      .data_i         (data_i),
      .src_rdy_i      (src_rdy_i),
      .dst_rdy_o      (dst_rdy_o),
      .write_data_o   (write_data),
      .write_strobe_o (write_strobe),
      .space_avail_i  (space_avail)
   );

   nobl_fifo #(.RAM_DEPTH(RAM_DEPTH)) u_nobl_fifo (
      .ext_clk        (ext_clk),
      .arst_n_i       (arst_n_i),
      .write_data_i   (write_data),
      .write_strobe_i (write_strobe),
      .space_avail_o  (space_avail),
      .read_strobe_i  (read_strobe),
      .read_data_o    (read_data),
      .data_avail_o   (data_avail),
      .ram_o          (ram_o),
      .ram_d_i        (ram_d_i)
   );

   word_join #(.BUF_DEPTH(BUF_DEPTH)) u_word_join (
      .ext_clk        (ext_clk),
      .arst_n_i       (arst_n_i),
      .read_data_i    (read_data),
      .data_avail_i   (data_avail),
      .read_strobe_o  (read_strobe),
      .data_o         (data_o),
      .src_rdy_o      (src_rdy_o),
      .dst_rdy_i      (dst_rdy_i)
   );

endmodule

/* hdl/fifo_cfg_pkg.sv */
// ==================================================
// Data word and half word types of the deep FIFO
// 36 bit word union, seen whole or as two halves
// Default SRAM and on-chip buffer depths
// ==================================================

package fifo_cfg_pkg;

   localparam int WORD_W = 36;   // User word width
   localparam int HALF_W = 18;   // SRAM data bus width

   typedef logic [WORD_W-1:0] word_t;
   typedef logic [HALF_W-1:0] half_t;

   // One word, or its two SRAM halves with index 0 the low half
   typedef union packed {
      word_t        word;
      half_t [1:0]  half;
   } word_u;

   localparam int DEF_RAM_DEPTH = 19;   // SRAM address bits
   localparam int DEF_BUF_DEPTH = 4;    // Words per on-chip buffer, power of two

endpackage

/* hdl/nobl_fifo.sv */
// ==================================================
// SRAM controller of the deep FIFO
// Ring of halves in NoBL SRAM, one access per cycle
// Write data delay line and read return tags
// ==================================================
`timescale 1ns/100ps

module nobl_fifo #(
   parameter int RAM_DEPTH = fifo_cfg_pkg::DEF_RAM_DEPTH
) (
   input  logic                 ext_clk,
   input  logic                 arst_n_i,
   input  fifo_cfg_pkg::half_t  write_data_i,
   input  logic                 write_strobe_i,
   output logic                 space_avail_o,
   input  logic                 read_strobe_i,
   output fifo_cfg_pkg::half_t  read_data_o,
   output logic                 data_avail_o,
   output nobl_pkg::sram_bus_t  ram_o,
   input  fifo_cfg_pkg::half_t  ram_d_i
);

   import fifo_cfg_pkg::*;
   import nobl_pkg::*;

   localparam logic [RAM_DEPTH:0] FULL_CNT = {1'b1, {RAM_DEPTH{1'b0}}};

   logic [RAM_DEPTH-1:0]   wr_ptr;
   logic [RAM_DEPTH-1:0]   rd_ptr;
   logic [RAM_DEPTH:0]     fill_cnt;     // Halves written and not yet requested
   logic                   do_write;
   logic                   do_read;

   logic [RAM_DEPTH-1:0]   addr_q;       // Pin registers
   logic                   we_n_q;
   logic                   en_n_q;       // Clock enable and load, low once running
   logic                   oe_n_q;
   logic                   ce1_n_q;
   half_t                  d_out_q;
   logic                   d_oe_q;

   logic [SRAM_LAT-1:0]    wr_pend;      // Write in flight, bit 0 on the address cycle
   half_t                  wd_pipe [SRAM_LAT];
   logic [JOIN_SLACK-1:0]  rd_pend;      // Read in flight, bit 0 on the address cycle

   assign space_avail_o = (fill_cnt != FULL_CNT);

   // Writes first, reads when the write side is idle or the ring is full
   assign do_write = write_strobe_i & space_avail_o;
   assign do_read  = read_strobe_i & (fill_cnt != '0) & ~do_write;

   // Read data goes straight from the pads, tagged by the read pipeline.
   // Reading a half still in the write delay line needs the SRAM's late
   // write forwarding.
   assign read_data_o  = ram_d_i;
   assign data_avail_o = rd_pend[JOIN_SLACK-1];   // SRAM_LAT after the address

   assign ram_o = '{
      address: ADDR_MAX'(addr_q),
      we_n:    we_n_q,
      ce_n:    en_n_q,
      ld_n:    en_n_q,
      oe_n:    oe_n_q,
      ce1_n:   ce1_n_q,
      d_out:   d_out_q,
      d_oe:    d_oe_q
   };

   // Address and write data path
   always_ff @(posedge ext_clk) begin
      addr_q     <= do_write ? wr_ptr : rd_ptr;
      wd_pipe[0] <= write_data_i;
      for (int i = 1; i < SRAM_LAT; i++) begin
         wd_pipe[i] <= wd_pipe[i-1];
      end
      d_out_q <= wd_pipe[SRAM_LAT-1];   // On pins SRAM_LAT after its address
   end

   always_ff @(posedge ext_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         fill_cnt <= '0;
         we_n_q   <= 1'b1;
         en_n_q   <= 1'b1;
         oe_n_q   <= 1'b1;
         ce1_n_q  <= 1'b1;
         d_oe_q   <= 1'b0;
         wr_pend  <= '0;
         rd_pend  <= '0;
      end else begin
         en_n_q  <= 1'b0;
         we_n_q  <= ~do_write;
         ce1_n_q <= ~(do_write | do_read);   // Deselect on idle cycles
         wr_pend <= SRAM_LAT'({wr_pend, do_write});
         rd_pend <= JOIN_SLACK'({rd_pend, do_read});
         d_oe_q  <= wr_pend[SRAM_LAT-1];
         oe_n_q  <= ~rd_pend[SRAM_LAT-1];    // SRAM drives in the next cycle
         if (do_write) begin
            wr_ptr   <= wr_ptr + 1'b1;
            fill_cnt <= fill_cnt + 1'b1;
         end
         if (do_read) begin
            rd_ptr   <= rd_ptr + 1'b1;
            fill_cnt <= fill_cnt - 1'b1;     // Never with a write
         end
      end
   end

endmodule

/* hdl/nobl_pkg.sv */
// ==================================================
// NoBL / ZBT pipelined SRAM pin bundle
// SRAM data latency and read slack of the join stage
// ==================================================

package nobl_pkg;

   localparam int ADDR_MAX = 19;   // Widest supported SRAM address

   // Address pins to data on the bus, same for read and write
   localparam int SRAM_LAT = 2;

   // Reads still uncounted by the join stage when it lowers read_strobe
   localparam int JOIN_SLACK = SRAM_LAT + 1;

   // All SRAM pins driven by the controller, control pins active low
   typedef struct packed {
      logic [ADDR_MAX-1:0]  address;   // Upper unused bits held zero
      logic                 we_n;      // Write enable
      logic                 ce_n;      // Clock enable
      logic                 ld_n;      // Load new address
      logic                 oe_n;      // Output enable, low in read data slot
      logic                 ce1_n;     // Chip enable, low on an access
      fifo_cfg_pkg::half_t  d_out;     // Write data
      logic                 d_oe;      // Write data pad enable
   } sram_bus_t;

endpackage

/* hdl/word_join.sv */
// ==================================================
// Output stage of the deep FIFO
// Pairs SRAM halves into words, FWFT word buffer
// Read throttle with room for reads in flight
// ==================================================
`timescale 1ns/100ps

module word_join #(
   parameter int BUF_DEPTH = fifo_cfg_pkg::DEF_BUF_DEPTH
) (
   input  logic                 ext_clk,
   input  logic                 arst_n_i,
   input  fifo_cfg_pkg::half_t  read_data_i,
   input  logic                 data_avail_i,
   output logic                 read_strobe_o,   // Low while almost full
   output fifo_cfg_pkg::word_t  data_o,
   output logic                 src_rdy_o,       // Not empty
   input  logic                 dst_rdy_i
);

   import fifo_cfg_pkg::*;
   import nobl_pkg::*;

   localparam int PW = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
   localparam int CW = $clog2(BUF_DEPTH + 1);
   localparam int HALVES = 2 * BUF_DEPTH;   // Must exceed JOIN_SLACK

   word_u          buf_mem [BUF_DEPTH];
   logic [PW-1:0]  wr_ptr;
   logic [PW-1:0]  rd_ptr;
   logic [CW-1:0]  count;                   // Whole words held
   half_t          low_q;                   // Low half waiting for its partner
   logic           low_vld;
   logic [CW:0]    used_halves;
   word_u          joined;
   logic           push;
   logic           pop;

   always_comb begin
      joined.half[0] = low_q;
      joined.half[1] = read_data_i;
   end

   assign push        = data_avail_i & low_vld;   // High half completes a word
   assign pop         = src_rdy_o & dst_rdy_i;
   assign src_rdy_o   = (count != '0);
   assign data_o      = buf_mem[rd_ptr].word;     // Head word falls through
   assign used_halves = {count, low_vld};         // 2 per word plus held half

   // Keep reading only while more than JOIN_SLACK halves are free
   assign read_strobe_o = (used_halves < (CW+1)'(HALVES - JOIN_SLACK));

   always_ff @(posedge ext_clk) begin
      if (data_avail_i && !low_vld) begin
         low_q <= read_data_i;
      end
      if (push) begin
         buf_mem[wr_ptr] <= joined;
      end
   end

   always_ff @(posedge ext_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count   <= '0;
         low_vld <= 1'b0;
      end else begin
         if (data_avail_i) begin
            low_vld <= ~low_vld;   // Halves alternate low, high
         end
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;
         endcase
      end
   end

endmodule

/* hdl/word_split.sv */
// ==================================================
// Input stage of the deep FIFO
// Small word buffer, sends each word as 2 halves
// ==================================================
`timescale 1ns/100ps

module word_split #(
   parameter int BUF_DEPTH = fifo_cfg_pkg::DEF_BUF_DEPTH
) (
   input  logic                 ext_clk,
   input  logic                 arst_n_i,
   input  fifo_cfg_pkg::word_t  data_i,
   input  logic                 src_rdy_i,
   output logic                 dst_rdy_o,        // Not full
   output fifo_cfg_pkg::half_t  write_data_o,
   output logic                 write_strobe_o,   // A half is waiting
   input  logic                 space_avail_i
);

   import fifo_cfg_pkg::*;

   localparam int PW = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
   localparam int CW = $clog2(BUF_DEPTH + 1);

   word_u          buf_mem [BUF_DEPTH];   // Word storage
   logic [PW-1:0]  wr_ptr;
   logic [PW-1:0]  rd_ptr;
   logic [CW-1:0]  count;                 // Words held
   logic           half_sel;              // Half of head word being offered
   logic           push;
   logic           half_move;
   logic           pop;

   assign dst_rdy_o      = (count != CW'(BUF_DEPTH));
   assign push           = src_rdy_i & dst_rdy_o;
   assign write_strobe_o = (count != '0);
   assign half_move      = write_strobe_o & space_avail_i;
   assign pop            = half_move & half_sel;   // High half gone, word done

   // Head word picked apart through the union, low half first
   assign write_data_o = buf_mem[rd_ptr].half[half_sel];

   always_ff @(posedge ext_clk) begin
      if (push) begin
         buf_mem[wr_ptr].word <= data_i;
      end
   end

   // Pointers wrap by overflow
   always_ff @(posedge ext_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         half_sel <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         if (half_move) begin
            half_sel <= ~half_sel;   // Back to low half after each word
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;               // Idle, or push and pop together
         endcase
      end
   end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the deep FIFO testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
      --top-module ext_fifo_tb -f ext_fifo.f; then
   echo "Verilator build failed"
   exit 1
fi

if ! sim_out=$(./obj_dir/Vext_fifo_tb +verilator+error+limit+1000); then
   echo "$sim_out"
   echo "Simulation exited with an error status"
   exit 1
fi
echo "$sim_out"

if echo "$sim_out" | grep -qx "RESULT: PASS"; then
   exit 0
fi
exit 1
